/* design/riscv_csr_pkg.sv */
package riscv_csr_pkg;

    typedef enum logic [1:0] {
        MODE_USER    = 2'b00,
        MODE_MACHINE = 2'b11
    } priv_mode_t;

    typedef logic [11:0] csr_addr_t;

    // Counters, read only
    localparam csr_addr_t CSR_ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t CSR_ADDR_TIME     = 12'hc01;
    localparam csr_addr_t CSR_ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t CSR_ADDR_TIMEH    = 12'hc81;

    // Machine trap setup and handling
    localparam csr_addr_t CSR_ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_ADDR_MIE      = 12'h304;
    localparam csr_addr_t CSR_ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_ADDR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_ADDR_MIP      = 12'h344;

    // Interrupt flag in bit 31, machine timer is code 7
    localparam logic [31:0] MCAUSE_TIMER_INT  = 32'h8000_0007;
    // Environment call from U is 8, from M is 11
    localparam logic [31:0] MCAUSE_ECALL_BASE = 32'd8;

    typedef struct packed {
        logic [13:0] rsvd_31_18;
        logic        mprv;
        logic [3:0]  rsvd_16_13;
        priv_mode_t  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    typedef struct packed {
        logic [19:0] rsvd_31_12;
        logic        meie;
        logic [2:0]  rsvd_10_8;
        logic        mtie;
        logic [2:0]  rsvd_6_4;
        logic        msie;
        logic [2:0]  rsvd_2_0;
    } mie_t;

    // Write-back word, seen by field depending on the target
    typedef union packed {
        logic [31:0] raw;
        mstatus_t    mstatus;
        mie_t        mie;
    } csr_word_u;

endpackage

/* design/csr_stage_pkg.sv */
package csr_stage_pkg;

    typedef enum logic [2:0] {
        CSR_X     = 3'd0,
        CSR_W     = 3'd1,
        CSR_S     = 3'd2,
        CSR_C     = 3'd3,
        CSR_ECALL = 3'd4,
        CSR_MRET  = 3'd5
    } csr_cmd_t;

    // Request from the execute stage
    typedef struct packed {
        csr_cmd_t                  cmd;
        riscv_csr_pkg::csr_addr_t  addr;
        logic [31:0]               op1;
    } csr_req_t;

    // Held for the cycle after the read
    typedef struct packed {
        logic                      we;
        csr_cmd_t                  cmd;
        riscv_csr_pkg::csr_addr_t  addr;
        logic [31:0]               op1;
    } csr_wb_t;

    // Trap side effects on the machine registers
    typedef struct packed {
        logic        take_interrupt;
        logic        take_ecall;
        logic        take_mret;
        logic [31:0] mcause;
        logic [31:0] mepc;
    } trap_update_t;

endpackage

/* design/csr_decode.sv */
`timescale 1ns/10ps

module csr_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    input  logic                    take_interrupt,
    input  csr_stage_pkg::csr_req_t req,
    output csr_stage_pkg::csr_req_t eff_req,
    output csr_stage_pkg::csr_wb_t  wb
);
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    logic addr_writable;
    logic write_cmd;

    // A flushed or interrupted slot becomes a bubble reading address 0
    always_comb begin
        if (flush || take_interrupt) begin
            eff_req = '{cmd: CSR_X, addr: '0, op1: '0};
        end else begin
            eff_req = req;
        end
    end

    always_comb begin
        case (eff_req.addr)
            CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
            CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE,
            CSR_ADDR_MTVAL, CSR_ADDR_MIP: addr_writable = 1'b1;
            default:                      addr_writable = 1'b0;
        endcase
    end

    assign write_cmd = (eff_req.cmd == CSR_W) || (eff_req.cmd == CSR_S) ||
                       (eff_req.cmd == CSR_C);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb <= '{we: 1'b0, cmd: CSR_X, addr: '0, op1: '0};
        end else begin
            wb.we   <= write_cmd && addr_writable;
            wb.cmd  <= eff_req.cmd;
            wb.addr <= eff_req.addr;
            wb.op1  <= eff_req.op1;
        end
    end

endmodule

/* design/csr_trap_ctrl.sv */
`timescale 1ns/10ps

module csr_trap_ctrl (
    input  logic                         clk,
    input  logic                         reset,
    input  csr_stage_pkg::csr_req_t      eff_req,
    input  logic                         interrupt_ready,
    input  logic [63:0]                  mtime,
    input  logic [63:0]                  mtimecmp,
    input  logic [31:0]                  fetch_pc,
    input  riscv_csr_pkg::mstatus_t      mstatus,
    input  riscv_csr_pkg::mie_t          mie,
    input  logic [31:0]                  mtvec,
    input  logic [31:0]                  mepc,
    output logic                         take_interrupt,
    output logic                         stall_request,
    output csr_stage_pkg::trap_update_t  trap,
    output logic [31:0]                  trap_vector,
    output csr_stage_pkg::csr_cmd_t      cmd_out,
    output riscv_csr_pkg::priv_mode_t    mode
);
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    // Below machine mode the global enable does not mask
    assign stall_request = (mtime >= mtimecmp) && mie.mtie &&
                           ((mode != MODE_MACHINE) || mstatus.mie);

    assign take_interrupt = stall_request && interrupt_ready;

    always_comb begin
        trap.take_interrupt = take_interrupt;
        trap.take_ecall     = !take_interrupt && (eff_req.cmd == CSR_ECALL);
        trap.take_mret      = !take_interrupt && (eff_req.cmd == CSR_MRET);
        trap.mcause         = take_interrupt ? MCAUSE_TIMER_INT
                                             : MCAUSE_ECALL_BASE + {30'd0, mode};
        trap.mepc           = fetch_pc;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode        <= MODE_MACHINE;
            trap_vector <= '0;
            cmd_out     <= CSR_X;
        end else if (take_interrupt) begin
            // Interrupt goes out to the pipeline as an ECALL
            mode        <= MODE_MACHINE;
            trap_vector <= mtvec;
            cmd_out     <= CSR_ECALL;
        end else begin
            cmd_out <= eff_req.cmd;
            case (eff_req.cmd)
                CSR_ECALL: begin
                    mode        <= MODE_MACHINE;
                    trap_vector <= mtvec;
                end
                CSR_MRET: begin
                    mode        <= mstatus.mpp;
                    trap_vector <= mepc;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* design/csr_regfile.sv */
`timescale 1ns/10ps

module csr_regfile #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                         clk,
    input  logic                         reset,
    input  csr_stage_pkg::csr_wb_t       wb,
    input  csr_stage_pkg::csr_cmd_t      cmd_wb,
    input  logic [31:0]                  rdata_prev,
    input  csr_stage_pkg::trap_update_t  trap,
    input  riscv_csr_pkg::priv_mode_t    mode,
    output riscv_csr_pkg::mstatus_t      mstatus,
    output riscv_csr_pkg::mie_t          mie,
    output logic [31:0]                  mtvec,
    output logic [31:0]                  mscratch,
    output logic [31:0]                  mepc,
    output logic [31:0]                  mcause,
    output logic [31:0]                  mtval,
    output logic [31:0]                  mip
);
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    csr_word_u wword;

    // Old value comes from the read done one cycle earlier
    always_comb begin
        case (cmd_wb)
            CSR_W:   wword.raw = wb.op1;
            CSR_S:   wword.raw = rdata_prev | wb.op1;
            CSR_C:   wword.raw = rdata_prev & ~wb.op1;
            default: wword.raw = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '{mpp: MODE_MACHINE, default: '0};
            mie      <= '0;
            mtvec    <= MTVEC_RESET;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mip      <= '0;
        end else begin
            if (wb.we) begin
                case (wb.addr)
                    CSR_ADDR_MSTATUS: begin
                        mstatus <= '{mprv: wword.mstatus.mprv,
                                     mpp:  wword.mstatus.mpp,
                                     mpie: wword.mstatus.mpie,
                                     mie:  wword.mstatus.mie,
                                     default: '0};
                    end
                    CSR_ADDR_MIE: begin
                        mie <= '{meie: wword.mie.meie,
                                 mtie: wword.mie.mtie,
                                 msie: wword.mie.msie,
                                 default: '0};
                    end
                    CSR_ADDR_MTVEC:    mtvec    <= wword.raw;
                    CSR_ADDR_MSCRATCH: mscratch <= wword.raw;
                    CSR_ADDR_MEPC:     mepc     <= wword.raw;
                    CSR_ADDR_MCAUSE:   mcause   <= wword.raw;
                    CSR_ADDR_MTVAL:    mtval    <= wword.raw;
                    CSR_ADDR_MIP:      mip      <= wword.raw;
                    default: begin
                    end
                endcase
            end

            // Trap updates come last so they override a write-back
            if (trap.take_interrupt) begin
                mstatus.mpp  <= mode;
                mstatus.mpie <= mstatus.mie;
                mstatus.mie  <= 1'b0;
                mcause       <= trap.mcause;
                mepc         <= trap.mepc;
            end
            if (trap.take_ecall) begin
                mcause <= trap.mcause;
            end
            if (trap.take_mret) begin
                mstatus.mpp <= MODE_USER;
                mstatus.mie <= mstatus.mpie;
                if (mstatus.mpp != MODE_MACHINE) begin
                    mstatus.mprv <= 1'b0;
                end
            end
        end
    end

endmodule

/* design/csr_read_result.sv */
`timescale 1ns/10ps

module csr_read_result (
    input  logic                     clk,
    input  logic                     reset,
    input  riscv_csr_pkg::csr_addr_t addr,
    input  logic [63:0]              cycle_count,
    input  logic [63:0]              time_count,
    input  riscv_csr_pkg::mstatus_t  mstatus,
    input  riscv_csr_pkg::mie_t      mie,
    input  logic [31:0]              mtvec,
    input  logic [31:0]              mscratch,
    input  logic [31:0]              mepc,
    input  logic [31:0]              mcause,
    input  logic [31:0]              mtval,
    input  logic [31:0]              mip,
    output logic [31:0]              csr_rdata
);
    import riscv_csr_pkg::*;

    always_ff @(posedge clk) begin
        if (reset) begin
            csr_rdata <= '0;
        end else begin
            case (addr)
                CSR_ADDR_CYCLE:    csr_rdata <= cycle_count[31:0];
                CSR_ADDR_TIME:     csr_rdata <= time_count[31:0];
                CSR_ADDR_CYCLEH:   csr_rdata <= cycle_count[63:32];
                CSR_ADDR_TIMEH:    csr_rdata <= time_count[63:32];
                // Reserved fields are held at zero in storage
                CSR_ADDR_MSTATUS:  csr_rdata <= mstatus;
                CSR_ADDR_MIE:      csr_rdata <= mie;
                CSR_ADDR_MTVEC:    csr_rdata <= mtvec;
                CSR_ADDR_MSCRATCH: csr_rdata <= mscratch;
                CSR_ADDR_MEPC:     csr_rdata <= mepc;
                CSR_ADDR_MCAUSE:   csr_rdata <= mcause;
                CSR_ADDR_MTVAL:    csr_rdata <= mtval;
                CSR_ADDR_MIP:      csr_rdata <= mip;
                default:           csr_rdata <= '0;
            endcase
        end
    end

endmodule

/* design/csr_stage.sv */
`timescale 1ns/10ps

module csr_stage #(
    parameter logic [31:0] MTVEC_RESET = 32'h0000_0100
) (
    input  logic                    clk,
    input  logic                    reset,
    input  csr_stage_pkg::csr_req_t req,
    input  logic                    flush,
    input  logic [63:0]             cycle_count,
    input  logic [63:0]             time_count,
    input  logic [63:0]             mtime,
    input  logic [63:0]             mtimecmp,
    input  logic                    interrupt_ready,
    input  logic [31:0]             fetch_pc,
    output logic [31:0]             csr_rdata,
    output logic [31:0]             trap_vector,
    output csr_stage_pkg::csr_cmd_t cmd_out,
    output logic                    stall_request
);
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    csr_req_t     eff_req;
    csr_wb_t      wb;
    trap_update_t trap;
    logic         take_interrupt;
    priv_mode_t   mode;
    mstatus_t     mstatus;
    mie_t         mie;
    logic [31:0]  mtvec;
    logic [31:0]  mscratch;
    logic [31:0]  mepc;
    logic [31:0]  mcause;
    logic [31:0]  mtval;
    logic [31:0]  mip;

    csr_decode u_decode (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .take_interrupt (take_interrupt),
        .req            (req),
        .eff_req        (eff_req),
        .wb             (wb)
    );

    csr_trap_ctrl u_trap_ctrl (
        .clk             (clk),
        .reset           (reset),
        .eff_req         (eff_req),
        .interrupt_ready (interrupt_ready),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .fetch_pc        (fetch_pc),
        .mstatus         (mstatus),
        .mie             (mie),
        .mtvec           (mtvec),
        .mepc            (mepc),
        .take_interrupt  (take_interrupt),
        .stall_request   (stall_request),
        .trap            (trap),
        .trap_vector     (trap_vector),
        .cmd_out         (cmd_out),
        .mode            (mode)
    );

    // Registered read data doubles as the old value for set and clear
    csr_regfile #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regfile (
        .clk        (clk),
        .reset      (reset),
        .wb         (wb),
        .cmd_wb     (wb.cmd),
        .rdata_prev (csr_rdata),
        .trap       (trap),
        .mode       (mode),
        .mstatus    (mstatus),
        .mie        (mie),
        .mtvec      (mtvec),
        .mscratch   (mscratch),
        .mepc       (mepc),
        .mcause     (mcause),
        .mtval      (mtval),
        .mip        (mip)
    );

    csr_read_result u_read_result (
        .clk         (clk),
        .reset       (reset),
        .addr        (eff_req.addr),
        .cycle_count (cycle_count),
        .time_count  (time_count),
        .mstatus     (mstatus),
        .mie         (mie),
        .mtvec       (mtvec),
        .mscratch    (mscratch),
        .mepc        (mepc),
        .mcause      (mcause),
        .mtval       (mtval),
        .mip         (mip),
        .csr_rdata   (csr_rdata)
    );

endmodule

/* verif/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// mprv, mpp, mpie and mie
localparam logic [31:0] MSTATUS_MASK = 32'h0002_1888;
// meie, mtie and msie
localparam logic [31:0] MIE_MASK     = 32'h0000_0888;

logic [31:0] m_mstatus;
logic [31:0] m_mie;
logic [31:0] m_mtvec;
logic [31:0] m_mscratch;
logic [31:0] m_mepc;
logic [31:0] m_mcause;
logic [31:0] m_mtval;
logic [31:0] m_mip;
logic [31:0] m_vector;
logic [1:0]  m_mode;

task automatic model_reset();
    m_mode     = 2'b11;
    m_mstatus  = 32'h0000_1800;
    m_mie      = '0;
    m_mtvec    = MTVEC_RESET;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mip      = '0;
    m_vector   = '0;
endtask

function automatic logic [31:0] model_read(input csr_addr_t addr);
    case (addr)
        CSR_ADDR_CYCLE:    return cycle_count[31:0];
        CSR_ADDR_CYCLEH:   return cycle_count[63:32];
        CSR_ADDR_TIME:     return time_count[31:0];
        CSR_ADDR_TIMEH:    return time_count[63:32];
        CSR_ADDR_MSTATUS:  return m_mstatus;
        CSR_ADDR_MIE:      return m_mie;
        CSR_ADDR_MTVEC:    return m_mtvec;
        CSR_ADDR_MSCRATCH: return m_mscratch;
        CSR_ADDR_MEPC:     return m_mepc;
        CSR_ADDR_MCAUSE:   return m_mcause;
        CSR_ADDR_MTVAL:    return m_mtval;
        CSR_ADDR_MIP:      return m_mip;
        default:           return '0;
    endcase
endfunction

task automatic model_write(input csr_cmd_t cmd, input csr_addr_t addr,
                           input logic [31:0] op1);
    logic [31:0] old_val;
    logic [31:0] new_val;
    old_val = model_read(addr);
    case (cmd)
        CSR_W:   new_val = op1;
        CSR_S:   new_val = old_val | op1;
        CSR_C:   new_val = old_val & ~op1;
        default: return;
    endcase
    // Counters and unknown addresses drop the write
    case (addr)
        CSR_ADDR_MSTATUS:  m_mstatus  = new_val & MSTATUS_MASK;
        CSR_ADDR_MIE:      m_mie      = new_val & MIE_MASK;
        CSR_ADDR_MTVEC:    m_mtvec    = new_val;
        CSR_ADDR_MSCRATCH: m_mscratch = new_val;
        CSR_ADDR_MEPC:     m_mepc     = new_val;
        CSR_ADDR_MCAUSE:   m_mcause   = new_val;
        CSR_ADDR_MTVAL:    m_mtval    = new_val;
        CSR_ADDR_MIP:      m_mip      = new_val;
        default: begin
        end
    endcase
endtask

task automatic model_ecall();
    m_mcause = 32'd8 + {30'd0, m_mode};
    m_mode   = 2'b11;
    m_vector = m_mtvec;
endtask

task automatic model_mret();
    logic [1:0] old_mpp;
    old_mpp          = m_mstatus[12:11];
    m_vector         = m_mepc;
    m_mode           = old_mpp;
    m_mstatus[3]     = m_mstatus[7];
    if (old_mpp != 2'b11) begin
        m_mstatus[17] = 1'b0;
    end
    m_mstatus[12:11] = 2'b00;
endtask

task automatic model_interrupt(input logic [31:0] pc);
    m_mstatus[12:11] = m_mode;
    m_mstatus[7]     = m_mstatus[3];
    m_mstatus[3]     = 1'b0;
    m_mcause         = 32'h8000_0007;
    m_mepc           = pc;
    m_mode           = 2'b11;
    m_vector         = m_mtvec;
endtask

task automatic model_cmd(input csr_cmd_t cmd, input csr_addr_t addr,
                         input logic [31:0] op1);
    case (cmd)
        CSR_ECALL: model_ecall();
        CSR_MRET:  model_mret();
        default:   model_write(cmd, addr, op1);
    endcase
endtask

`endif

/* verif/csr_stage_tb.sv */
`timescale 1ns/10ps

module csr_stage_tb;
    import riscv_csr_pkg::*;
    import csr_stage_pkg::*;

    localparam logic [31:0] MTVEC_RESET = 32'h8000_0040;

    logic        clk;
    logic        reset;
    csr_req_t    req;
    logic        flush;
    logic [63:0] cycle_count;
    logic [63:0] time_count;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        interrupt_ready;
    logic [31:0] fetch_pc;
    logic [31:0] csr_rdata;
    logic [31:0] trap_vector;
    csr_cmd_t    cmd_out;
    logic        stall_request;

    logic [31:0] rng_state;
    logic [31:0] got_rdata;
    logic [31:0] got_vector;
    csr_cmd_t    got_cmd;
    int          error_count;
    int          check_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic        timeout_hit;

    csr_addr_t kept_addrs [8] = '{CSR_ADDR_MSTATUS, CSR_ADDR_MIE, CSR_ADDR_MTVEC,
                                  CSR_ADDR_MSCRATCH, CSR_ADDR_MEPC, CSR_ADDR_MCAUSE,
                                  CSR_ADDR_MTVAL, CSR_ADDR_MIP};
    csr_addr_t plain_addrs [8] = '{CSR_ADDR_MSCRATCH, CSR_ADDR_MTVEC, CSR_ADDR_MEPC,
                                   CSR_ADDR_MTVAL, CSR_ADDR_MIP, CSR_ADDR_MSCRATCH,
                                   CSR_ADDR_MEPC, CSR_ADDR_MIP};
    csr_addr_t counter_addrs [4] = '{CSR_ADDR_CYCLE, CSR_ADDR_CYCLEH,
                                     CSR_ADDR_TIME, CSR_ADDR_TIMEH};

    `include "csr_model.svh"

    csr_stage #(
        .MTVEC_RESET (MTVEC_RESET)
    ) uut (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .flush           (flush),
        .cycle_count     (cycle_count),
        .time_count      (time_count),
        .mtime           (mtime),
        .mtimecmp        (mtimecmp),
        .interrupt_ready (interrupt_ready),
        .fetch_pc        (fetch_pc),
        .csr_rdata       (csr_rdata),
        .trap_vector     (trap_vector),
        .cmd_out         (cmd_out),
        .stall_request   (stall_request)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic csr_cmd_t random_write_cmd();
        case (next_random() % 3)
            0:       return CSR_W;
            1:       return CSR_S;
            default: return CSR_C;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Request in one cycle, bubble in the next, outputs sampled mid-bubble
    task automatic issue(input csr_cmd_t cmd_in, input csr_addr_t addr_in,
                         input logic [31:0] op1_in, input logic flush_in);
        @(posedge clk);
        req   <= '{cmd_in, addr_in, op1_in};
        flush <= flush_in;
        @(posedge clk);
        req   <= '{CSR_X, 12'h000, 32'd0};
        flush <= 1'b0;
        @(negedge clk);
        got_rdata  = csr_rdata;
        got_vector = trap_vector;
        got_cmd    = cmd_out;
    endtask

    task automatic exec_cmd(input csr_cmd_t cmd_in, input csr_addr_t addr_in,
                            input logic [31:0] op1_in, input logic flush_in);
        csr_cmd_t  eff_cmd;
        csr_addr_t eff_addr;
        eff_cmd  = flush_in ? CSR_X : cmd_in;
        eff_addr = flush_in ? 12'h000 : addr_in;
        issue(cmd_in, addr_in, op1_in, flush_in);
        check_value(got_rdata, model_read(eff_addr), $sformatf("rdata at %h", addr_in));
        check_value({29'd0, got_cmd}, {29'd0, eff_cmd}, "cmd_out");
        model_cmd(eff_cmd, eff_addr, op1_in);
        check_value(got_vector, m_vector, "trap_vector");
    endtask

    task automatic set_counts();
        @(posedge clk);
        cycle_count <= {next_random(), next_random()};
        time_count  <= {next_random(), next_random()};
    endtask

    task automatic wait_for_stall(input logic level, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (stall_request !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (stall_request !== level) begin
            timeout_hit = 1'b1;
            test_errors++;
            $display("Timeout at %0t: stall_request never reached %b in %0d cycles",
                     $time, level, max_cycles);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        logic [2:0]  sel;
        logic [31:0] r;
        logic [31:0] status;
        logic [31:0] pc;
        logic [63:0] t;
        csr_addr_t   addr;

        rng_state       = 32'hed8a_0c03;
        reset           = 1'b1;
        req             = '{CSR_X, 12'h000, 32'd0};
        flush           = 1'b0;
        cycle_count     = '0;
        time_count      = '0;
        mtime           = '0;
        mtimecmp        = '1;
        interrupt_ready = 1'b0;
        fetch_pc        = '0;
        error_count     = 0;
        check_count     = 0;
        test_errors     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        timeout_hit     = 1'b0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        model_reset();
        check_value(csr_rdata, 32'd0, "csr_rdata after reset");
        check_value(trap_vector, 32'd0, "trap_vector after reset");
        check_value({29'd0, cmd_out}, {29'd0, CSR_X}, "cmd_out after reset");
        foreach (kept_addrs[i]) begin
            exec_cmd(CSR_X, kept_addrs[i], 32'd0, 1'b0);
        end
        end_test("reset");

        repeat (40) begin
            r    = next_random();
            sel  = r[2:0];
            addr = plain_addrs[sel];
            exec_cmd(random_write_cmd(), addr, next_random(), 1'b0);
            exec_cmd(CSR_X, addr, 32'd0, 1'b0);
        end
        end_test("write_set_clear");

        repeat (10) begin
            addr = next_random() % 2 == 0 ? CSR_ADDR_MSTATUS : CSR_ADDR_MIE;
            exec_cmd(random_write_cmd(), addr, next_random(), 1'b0);
            exec_cmd(CSR_X, addr, 32'd0, 1'b0);
        end
        set_counts();
        foreach (counter_addrs[i]) begin
            exec_cmd(CSR_W, counter_addrs[i], next_random(), 1'b0);
            exec_cmd(CSR_X, counter_addrs[i], 32'd0, 1'b0);
        end
        // 0x700..0x7ff holds no kept register
        repeat (8) begin
            r    = next_random();
            addr = {4'h7, r[7:0]};
            exec_cmd(CSR_W, addr, next_random(), 1'b0);
            exec_cmd(CSR_X, addr, 32'd0, 1'b0);
        end
        end_test("masks_and_read_only");

        exec_cmd(CSR_ECALL, 12'h000, 32'd0, 1'b0);
        exec_cmd(CSR_X, CSR_ADDR_MCAUSE, 32'd0, 1'b0);
        check_value(got_rdata, 32'd11, "mcause for machine ECALL");
        exec_cmd(CSR_W, CSR_ADDR_MSTATUS, 32'd0, 1'b0);
        exec_cmd(CSR_MRET, 12'h000, 32'd0, 1'b0);
        exec_cmd(CSR_ECALL, 12'h000, 32'd0, 1'b0);
        exec_cmd(CSR_X, CSR_ADDR_MCAUSE, 32'd0, 1'b0);
        check_value(got_rdata, 32'd8, "mcause for user ECALL");
        end_test("ecall");

        repeat (6) begin
            r              = next_random();
            status         = r & MSTATUS_MASK;
            status[12:11]  = r[0] ? 2'b11 : 2'b00;
            exec_cmd(CSR_W, CSR_ADDR_MSTATUS, status, 1'b0);
            exec_cmd(CSR_W, CSR_ADDR_MEPC, next_random(), 1'b0);
            exec_cmd(CSR_MRET, 12'h000, 32'd0, 1'b0);
            exec_cmd(CSR_X, CSR_ADDR_MSTATUS, 32'd0, 1'b0);
            // Back to machine mode for the next round
            exec_cmd(CSR_ECALL, 12'h000, 32'd0, 1'b0);
        end
        end_test("mret");

        exec_cmd(CSR_W, CSR_ADDR_MTVEC, next_random() & 32'hffff_fffc, 1'b0);
        exec_cmd(CSR_W, CSR_ADDR_MIE, 32'h0000_0080, 1'b0);
        exec_cmd(CSR_S, CSR_ADDR_MSTATUS, 32'h0000_0008, 1'b0);
        r = next_random();
        t = {1'b1, r[30:0], next_random()};
        r = next_random();
        @(posedge clk);
        mtime    <= t;
        mtimecmp <= t - {56'd0, r[7:0]};
        wait_for_stall(1'b1, 5);
        if (!timeout_hit) begin
            pc = next_random() & 32'hffff_fffc;
            @(posedge clk);
            interrupt_ready <= 1'b1;
            fetch_pc        <= pc;
            @(posedge clk);
            interrupt_ready <= 1'b0;
            @(negedge clk);
            model_interrupt(pc);
            check_value({29'd0, cmd_out}, {29'd0, CSR_ECALL}, "cmd_out on interrupt");
            check_value(trap_vector, m_mtvec, "trap_vector on interrupt");
            exec_cmd(CSR_X, CSR_ADDR_MCAUSE, 32'd0, 1'b0);
            check_value(got_rdata, MCAUSE_TIMER_INT, "mcause after interrupt");
            exec_cmd(CSR_X, CSR_ADDR_MEPC, 32'd0, 1'b0);
            exec_cmd(CSR_X, CSR_ADDR_MSTATUS, 32'd0, 1'b0);
            // Timer still pending, masked by mie in machine mode
            repeat (4) begin
                @(negedge clk);
                check_value({31'd0, stall_request}, 32'd0, "stall_request with mie clear");
            end
        end
        @(posedge clk);
        mtimecmp <= '1;
        end_test("timer_interrupt");

        repeat (6) begin
            exec_cmd(CSR_W, CSR_ADDR_MSCRATCH, next_random(), 1'b1);
            exec_cmd(CSR_X, CSR_ADDR_MSCRATCH, 32'd0, 1'b0);
        end
        end_test("flush");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && !timeout_hit) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+verif
design/riscv_csr_pkg.sv
design/csr_stage_pkg.sv
design/csr_decode.sv
design/csr_trap_ctrl.sv
design/csr_regfile.sv
design/csr_read_result.sv
design/csr_stage.sv
verif/csr_stage_tb.sv

/* Makefile */
TOP := csr_stage_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
